/* Bender.yml */
package:
  name: div_array

sources:
  # shared package first
  - common/div_pkg.sv
  - divider/div_iter_unit.sv
  - verilog/div_dispatch.sv
  - verilog/div_collect.sv
  - verilog/div_array.sv

  # testbench
  - target: test
    files:
      - bench/div_array_tb.sv

/* bench/div_array_tb.sv */
//----------------------------------------------------------------------
// testbench for the divide array, table driven, responses in order
// resp_rdy toggles randomly so lanes back up under load
//----------------------------------------------------------------------

`default_nettype none

module div_array_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import div_pkg::*;

  //----------------------------------------------------------------------
  // table and limits
  //----------------------------------------------------------------------

  localparam int NUM_VEC    = 14;
  localparam int CLK_NS     = 20;
  localparam int RESET_CYC  = 5;
  // forty cycles per divide covers worst back-pressure
  localparam int TIMEOUT_NS = NUM_VEC * 40 * CLK_NS + RESET_CYC * CLK_NS;

  // one table row holds request fields then expected result
  typedef struct packed {
    div_fn_e           fn;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] rem;
    logic [DATA_W-1:0] quot;
  } div_vec_t;

  div_vec_t  tbl [NUM_VEC];

  logic      clk;
  logic      reset;
  logic      req_val;
  logic      req_rdy;
  div_req_t  req_msg;
  logic      resp_val;
  logic      resp_rdy;
  div_resp_t resp_msg;

  integer      seed;
  logic [31:0] rnd;
  int          rx_count;

  div_array dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  always #(CLK_NS / 2) clk = ~clk;

  //----------------------------------------------------------------------
  // helpers
  //----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  // expected values worked out by hand from the divide rules
  task automatic load_table();
    // unsigned with ordinary and extreme operands
    tbl[0]  = '{DIV_UNSIGNED, 32'd100,        32'd7,        32'd2,        32'd14};
    tbl[1]  = '{DIV_UNSIGNED, 32'hFFFF_FFFF,  32'd1,        32'd0,        32'hFFFF_FFFF};
    tbl[2]  = '{DIV_UNSIGNED, 32'hFFFF_FFFF,  32'hFFFF_FFFF, 32'd0,       32'd1};
    tbl[3]  = '{DIV_UNSIGNED, 32'h8000_0000,  32'd3,        32'd2,        32'h2AAA_AAAA};
    tbl[4]  = '{DIV_UNSIGNED, 32'd5,          32'd10,       32'd5,        32'd0};
    // signed over all four sign pairs of 100 / 7
    tbl[5]  = '{DIV_SIGNED,   32'd100,        32'd7,        32'd2,        32'd14};
    tbl[6]  = '{DIV_SIGNED,   32'hFFFF_FF9C,  32'd7,        32'hFFFF_FFFE, 32'hFFFF_FFF2};
    tbl[7]  = '{DIV_SIGNED,   32'd100,        32'hFFFF_FFF9, 32'd2,       32'hFFFF_FFF2};
    tbl[8]  = '{DIV_SIGNED,   32'hFFFF_FF9C,  32'hFFFF_FFF9, 32'hFFFF_FFFE, 32'd14};
    // most negative over minus one wraps back to itself
    tbl[9]  = '{DIV_SIGNED,   32'h8000_0000,  32'hFFFF_FFFF, 32'd0,       32'h8000_0000};
    // divide by zero gives an all ones quotient magnitude
    tbl[10] = '{DIV_UNSIGNED, 32'h1234_5678,  32'd0,        32'h1234_5678, 32'hFFFF_FFFF};
    tbl[11] = '{DIV_SIGNED,   32'hFFFF_FFEC,  32'd0,        32'hFFFF_FFEC, 32'd1};
    tbl[12] = '{DIV_SIGNED,   32'd20,         32'd0,        32'd20,       32'hFFFF_FFFF};
    // -7 / 2 truncates toward zero
    tbl[13] = '{DIV_SIGNED,   32'hFFFF_FFF9,  32'd2,        32'hFFFF_FFFF, 32'hFFFF_FFFD};
  endtask

  // hold the request until a rising edge sees req_rdy
  task automatic send_request(input div_vec_t v);
    logic accepted;
    accepted     = 1'b0;
    req_val      = 1'b1;
    req_msg.fn   = v.fn;
    req_msg.a    = v.a;
    req_msg.b    = v.b;
    while (!accepted) begin
      @(negedge clk);
      accepted = req_rdy;
      @(posedge clk);
      #2;
    end
  endtask

  //----------------------------------------------------------------------
  // main sequence
  //----------------------------------------------------------------------

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    req_val     = 1'b0;
    req_msg     = '0;
    load_table();

    repeat (RESET_CYC) @(posedge clk);
    #2;
    reset = 1'b0;

    // idle state right out of reset
    @(negedge clk);
    check_value("resp_val", {31'd0, resp_val}, 32'd0);
    check_value("req_rdy", {31'd0, req_rdy}, 32'd1);
    @(posedge clk);
    #2;

    // back to back so four lanes fill up at once
    for (int i = 0; i < NUM_VEC; i++) begin
      send_request(tbl[i]);
    end
    req_val = 1'b0;
    req_msg = '0;

    wait (rx_count == NUM_VEC);
    // any extra response shows up in this quiet tail
    repeat (40) @(posedge clk);
    @(negedge clk);
    check_value("resp_val", {31'd0, resp_val}, 32'd0);

    $display("PASS: all tests");
    $finish;
  end

  //----------------------------------------------------------------------
  // response side
  //----------------------------------------------------------------------

  // random back-pressure with ready about three cycles in four
  initial begin
    seed     = 32'h7918;
    resp_rdy = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      rnd      = $random(seed);
      resp_rdy = (rnd[1:0] != 2'b00);
    end
  end

  // a transfer is decided by the values that hold before the edge
  initial begin
    rx_count = 0;
    forever begin
      @(negedge clk);
      if (!reset && resp_val && resp_rdy) begin
        if (rx_count >= NUM_VEC) begin
          $display("extra response at %0t after all %0d results arrived", $time, NUM_VEC);
          $display("FAIL: see errors above");
          $fatal(1, "response count exceeded");
        end
        check_value("resp_msg.rem", resp_msg.rem, tbl[rx_count].rem);
        check_value("resp_msg.quot", resp_msg.quot, tbl[rx_count].quot);
        rx_count++;
      end
    end
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: only %0d of %0d responses arrived", rx_count, NUM_VEC);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* build.f */
common/div_pkg.sv
divider/div_iter_unit.sv
verilog/div_dispatch.sv
verilog/div_collect.sv
verilog/div_array.sv
bench/div_array_tb.sv

/* common/div_pkg.sv */
//----------------------------------------------------------------------
// shared types and sizes for the four-lane divide array
// widths below are fixed and the lane math assumes 32-bit operands
//----------------------------------------------------------------------

`default_nettype none

package div_pkg;

  //----------------------------------------------------------------------
  // sizes
  //----------------------------------------------------------------------

  // lanes in the array, pointer width must cover them
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 2;

  // operand width
  localparam int DATA_W    = 32;

  // one restoring step per bit of dividend
  localparam int DIV_STEPS = 32;
  // counter has to reach DIV_STEPS itself
  localparam int CNT_W     = 6;

  //----------------------------------------------------------------------
  // enums
  //----------------------------------------------------------------------

  // operation select carried in the request
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  // lane control states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

  //----------------------------------------------------------------------
  // messages
  //----------------------------------------------------------------------

  // request, fn sits in the top bit
  typedef struct packed {
    div_fn_e             fn;
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
  } div_req_t;

  // response, remainder in the upper half
  typedef struct packed {
    logic [DATA_W-1:0]   rem;
    logic [DATA_W-1:0]   quot;
  } div_resp_t;

endpackage

`default_nettype wire

/* divider/div_iter_unit.sv */
//----------------------------------------------------------------------
// one restoring divide lane, 33 cycles from accept to resp_val
// divide by zero is not trapped, quotient magnitude comes back all ones
//----------------------------------------------------------------------

`default_nettype none

module div_iter_unit (
  input  logic               clk,
  input  logic               reset,

  // request side
  input  logic               req_val,
  output logic               req_rdy,
  input  div_pkg::div_req_t  req_msg,

  // response side
  output logic               resp_val,
  input  logic               resp_rdy,
  output div_pkg::div_resp_t resp_msg
);

  import div_pkg::*;

  //----------------------------------------------------------------------
  // declarations
  //----------------------------------------------------------------------

  // control
  div_state_e          state;
  logic [CNT_W-1:0]    count;
  logic                req_go;
  logic                resp_go;
  logic                step_en;

  // operand magnitudes at the input
  logic                req_signed;
  logic [DATA_W-1:0]   a_mag;
  logic [DATA_W-1:0]   b_mag;

  // remainder/quotient register and divisor, both 2*DATA_W+1 wide
  logic [2*DATA_W:0]   rq;
  logic [2*DATA_W:0]   dvs;
  logic [2*DATA_W:0]   rq_shift;
  logic [2*DATA_W:0]   rq_diff;
  logic [2*DATA_W:0]   rq_step;

  // latched request info for sign correction
  div_fn_e             fn_q;
  logic                a_neg;
  logic                b_neg;

  // result magnitudes and fix-up
  logic [DATA_W-1:0]   quot_mag;
  logic [DATA_W-1:0]   rem_mag;
  logic                quot_neg;
  logic                rem_neg;

  //----------------------------------------------------------------------
  // control FSM
  //----------------------------------------------------------------------

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // steps run on counts 0..DIV_STEPS-1
  // count == DIV_STEPS is the settle cycle before done
  assign step_en  = (state == ST_CALC) && (count != CNT_W'(DIV_STEPS));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      unique case (state)
        ST_IDLE: begin
          if (req_go) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          if (count == CNT_W'(DIV_STEPS)) begin
            state <= ST_DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        ST_DONE: begin
          // hold result until the collector takes it
          if (resp_go) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //----------------------------------------------------------------------
  // operand capture
  //----------------------------------------------------------------------

  // only signed requests take absolute values
  assign req_signed = (req_msg.fn == DIV_SIGNED);
  assign a_mag = (req_signed && req_msg.a[DATA_W-1]) ? -req_msg.a : req_msg.a;
  assign b_mag = (req_signed && req_msg.b[DATA_W-1]) ? -req_msg.b : req_msg.b;

  //----------------------------------------------------------------------
  // restoring step
  //----------------------------------------------------------------------

  // partial remainder lives in rq[2*DATA_W:DATA_W], quotient fills the bottom
  assign rq_shift = rq << 1;
  assign rq_diff  = rq_shift - dvs;

  // negative difference restores the shifted value with a zero bit
  assign rq_step  = rq_diff[2*DATA_W] ? {rq_shift[2*DATA_W:1], 1'b0}
                                      : {rq_diff[2*DATA_W:1], 1'b1};

  always_ff @(posedge clk) begin
    if (req_go) begin
      fn_q  <= req_msg.fn;
      a_neg <= req_msg.a[DATA_W-1];
      b_neg <= req_msg.b[DATA_W-1];
      rq    <= {{(DATA_W+1){1'b0}}, a_mag};
      // divisor lines up with the partial remainder
      dvs   <= {1'b0, b_mag, {DATA_W{1'b0}}};
    end else if (step_en) begin
      rq    <= rq_step;
    end
  end

  //----------------------------------------------------------------------
  // sign correction
  //----------------------------------------------------------------------

  assign quot_mag = rq[DATA_W-1:0];
  assign rem_mag  = rq[2*DATA_W-1:DATA_W];

  // quotient flips on differing signs, remainder follows the dividend
  assign quot_neg = (fn_q == DIV_SIGNED) && (a_neg ^ b_neg);
  assign rem_neg  = (fn_q == DIV_SIGNED) && a_neg;

  always_comb begin
    resp_msg.quot = quot_neg ? -quot_mag : quot_mag;
    resp_msg.rem  = rem_neg ? -rem_mag : rem_mag;
  end

endmodule

`default_nettype wire

/* verilog/div_array.sv */
//----------------------------------------------------------------------
// four divide lanes behind a dispatcher and a collector
// results leave in request order, minimum latency 33 cycles
//----------------------------------------------------------------------

`default_nettype none

module div_array (
  input  logic               clk,
  input  logic               reset,

  // request stream
  input  logic               req_val,
  output logic               req_rdy,
  input  div_pkg::div_req_t  req_msg,

  // response stream
  output logic               resp_val,
  input  logic               resp_rdy,
  output div_pkg::div_resp_t resp_msg
);

  import div_pkg::*;

  //----------------------------------------------------------------------
  // lane wiring
  //----------------------------------------------------------------------

  logic [NUM_LANES-1:0] lane_req_val;
  logic [NUM_LANES-1:0] lane_req_rdy;
  div_req_t             lane_req_msg;

  logic [NUM_LANES-1:0] lane_resp_val;
  logic [NUM_LANES-1:0] lane_resp_rdy;
  div_resp_t            lane_resp_msg [NUM_LANES];

  // request side rotation
  div_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req_msg      (req_msg),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy),
    .lane_req_msg (lane_req_msg)
  );

  // lanes share the request payload
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    div_iter_unit u_lane (
      .clk      (clk),
      .reset    (reset),
      .req_val  (lane_req_val[i]),
      .req_rdy  (lane_req_rdy[i]),
      .req_msg  (lane_req_msg),
      .resp_val (lane_resp_val[i]),
      .resp_rdy (lane_resp_rdy[i]),
      .resp_msg (lane_resp_msg[i])
    );
  end

  // response side rotation
  div_collect u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_resp_val (lane_resp_val),
    .lane_resp_rdy (lane_resp_rdy),
    .lane_resp_msg (lane_resp_msg),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .resp_msg      (resp_msg)
  );

endmodule

`default_nettype wire

/* verilog/div_collect.sv */
//----------------------------------------------------------------------
// round-robin response drain in issue order, no added latency
// output back-pressure holds the pointed lane in its done state
//----------------------------------------------------------------------

`default_nettype none

module div_collect (
  input  logic                          clk,
  input  logic                          reset,

  // per-lane response side
  input  logic [div_pkg::NUM_LANES-1:0] lane_resp_val,
  output logic [div_pkg::NUM_LANES-1:0] lane_resp_rdy,
  input  div_pkg::div_resp_t            lane_resp_msg [div_pkg::NUM_LANES],

  // outgoing response stream
  output logic                          resp_val,
  input  logic                          resp_rdy,
  output div_pkg::div_resp_t            resp_msg
);

  import div_pkg::*;

  //----------------------------------------------------------------------
  // drain pointer
  //----------------------------------------------------------------------

  logic [LANE_W-1:0] drain_ptr;
  logic              resp_go;

  assign resp_go = resp_val && resp_rdy;

  // steps after each output transfer, so it trails the issue pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr <= '0;
    end else if (resp_go) begin
      if (drain_ptr == LANE_W'(NUM_LANES - 1)) begin
        drain_ptr <= '0;
      end else begin
        drain_ptr <= drain_ptr + 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // output mux
  //----------------------------------------------------------------------

  assign resp_val = lane_resp_val[drain_ptr];
  assign resp_msg = lane_resp_msg[drain_ptr];

  // other lanes finish and wait in their done state
  always_comb begin
    lane_resp_rdy            = '0;
    lane_resp_rdy[drain_ptr] = resp_rdy;
  end

endmodule

`default_nettype wire

/* verilog/div_dispatch.sv */
//----------------------------------------------------------------------
// round-robin request steering, no added latency
// input stalls on a busy pointed lane even if others sit idle
//----------------------------------------------------------------------

`default_nettype none

module div_dispatch (
  input  logic                          clk,
  input  logic                          reset,

  // incoming request stream
  input  logic                          req_val,
  output logic                          req_rdy,
  input  div_pkg::div_req_t             req_msg,

  // per-lane request side
  output logic [div_pkg::NUM_LANES-1:0] lane_req_val,
  input  logic [div_pkg::NUM_LANES-1:0] lane_req_rdy,
  output div_pkg::div_req_t             lane_req_msg
);

  import div_pkg::*;

  //----------------------------------------------------------------------
  // issue pointer
  //----------------------------------------------------------------------

  logic [LANE_W-1:0] issue_ptr;
  logic              req_go;

  assign req_go = req_val && req_rdy;

  // moves one lane on every accepted request
  always_ff @(posedge clk) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (req_go) begin
      if (issue_ptr == LANE_W'(NUM_LANES - 1)) begin
        issue_ptr <= '0;
      end else begin
        issue_ptr <= issue_ptr + 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // steering
  //----------------------------------------------------------------------

  // only the pointed lane ever sees val
  always_comb begin
    lane_req_val            = '0;
    lane_req_val[issue_ptr] = req_val;
  end

  // readiness comes from the pointed lane alone
  assign req_rdy = lane_req_rdy[issue_ptr];

  // payload is shared, val picks the taker
  assign lane_req_msg = req_msg;

endmodule

`default_nettype wire
